// File: Makefile
VERILATOR ?= verilator
TOP       ?= exec_core_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_EXE   ?= $(TOP)_sim

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(SIM_EXE)
	@out="$$(./$(OBJ_DIR)/$(SIM_EXE) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
  input  logic [31:0]       i_op1,
  input  logic [31:0]       i_op2,
  input  mips_pkg::alu_op_e i_control,
  output logic [31:0]       o_result,
  output logic              o_zero
);

  logic [4:0] shamt;

  assign shamt = i_op1[4:0];  // shifts move op2 by op1

  always_comb begin
    case (i_control)
      mips_pkg::ALU_ADD: begin
        o_result = i_op1 + i_op2;
      end
      mips_pkg::ALU_SUB: begin
        o_result = i_op1 - i_op2;
      end
      mips_pkg::ALU_AND: begin
        o_result = i_op1 & i_op2;
      end
      mips_pkg::ALU_OR: begin
        o_result = i_op1 | i_op2;
      end
      mips_pkg::ALU_XOR: begin
        o_result = i_op1 ^ i_op2;
      end
      mips_pkg::ALU_NOR: begin
        o_result = ~(i_op1 | i_op2);
      end
      mips_pkg::ALU_SLT: begin
        o_result = {31'b0, $signed(i_op1) < $signed(i_op2)};
      end
      mips_pkg::ALU_SLL: begin
        o_result = i_op2 << shamt;
      end
      mips_pkg::ALU_SRL: begin
        o_result = i_op2 >> shamt;
      end
      mips_pkg::ALU_SRA: begin
        o_result = $unsigned($signed(i_op2) >>> shamt);  // keeps sign
      end
      mips_pkg::ALU_LUI: begin
        o_result = {i_op2[15:0], 16'b0};
      end
      default: begin
        o_result = i_op1 + i_op2;
      end
    endcase
  end

  assign o_zero = (o_result == 32'd0);

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_instr_valid,
  input  logic [31:0]       i_instr,
  input  logic [31:0]       i_pc,
  input  logic [31:0]       i_rdata_a,
  input  logic [31:0]       i_rdata_b,
  output logic [4:0]        o_raddr_a,
  output logic [4:0]        o_raddr_b,
  output mips_pkg::dec_t    o_dec
);

  logic [5:0]      opcode;
  logic [4:0]      rs;
  logic [4:0]      rt;
  logic [4:0]      rd;
  logic [25:0]     imm;
  mips_pkg::ctrl_t ctrl;

  assign opcode = i_instr[31:26];
  assign rs     = i_instr[25:21];
  assign rt     = i_instr[20:16];
  assign rd     = i_instr[15:11];
  assign imm    = i_instr[25:0];  // funct and shamt ride along in here

  assign o_raddr_a = rs;
  assign o_raddr_b = rt;

  always_comb begin
    ctrl = '0;  // unknown opcode decodes as a no-op
    case (mips_pkg::opcode_e'(opcode))
      mips_pkg::R_TYPE: begin
        ctrl.reg_write  = 1'b1;
        ctrl.reg_dst_rd = 1'b1;
      end
      mips_pkg::ADDI, mips_pkg::SLTI: begin
        ctrl.alu_src_op2 = 1'b1;
        ctrl.ext_op      = 1'b1;
        ctrl.reg_write   = 1'b1;
      end
      mips_pkg::ANDI, mips_pkg::ORI, mips_pkg::XORI, mips_pkg::LUI: begin
        ctrl.alu_src_op2 = 1'b1;  // zero extended
        ctrl.reg_write   = 1'b1;
      end
      mips_pkg::BEQ: begin
        ctrl.ext_op = 1'b1;
        ctrl.beq    = 1'b1;
      end
      mips_pkg::BNE: begin
        ctrl.ext_op = 1'b1;
        ctrl.bne    = 1'b1;
      end
      mips_pkg::J: begin
        ctrl.jump = 1'b1;
      end
      mips_pkg::JAL: begin
        ctrl.jump      = 1'b1;
        ctrl.link      = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      default: ;
    endcase
    if (ctrl != '0) begin
      ctrl.op = mips_pkg::opcode_e'(opcode);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_dec.valid <= 1'b0;
      o_dec.ctrl  <= '0;
    end else begin
      o_dec.valid <= i_instr_valid;
      o_dec.pc    <= i_pc;
      o_dec.imm   <= imm;
      o_dec.op1   <= i_rdata_a;
      o_dec.op2   <= i_rdata_b;
      o_dec.rs    <= rs;
      o_dec.rt    <= rt;
      o_dec.rd    <= rd;
      o_dec.ctrl  <= ctrl;
    end
  end

endmodule

// File: logic/exec_core_top.sv
`timescale 1ns/1ps

module exec_core_top #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_instr_valid,
  input  logic [31:0] i_instr,
  input  logic [31:0] i_pc,
  output logic        o_branch_valid,
  output logic        o_pcsrc,
  output logic [31:0] o_next_pc,
  output logic        o_retire_valid,
  output logic        o_retire_we,
  output logic [4:0]  o_retire_addr,
  output logic [31:0] o_retire_data
);

  mips_pkg::dec_t dec;
  mips_pkg::exe_t exe;
  mips_pkg::wb_t  wb;
  logic [4:0]     raddr_a;
  logic [4:0]     raddr_b;
  logic [31:0]    rdata_a;
  logic [31:0]    rdata_b;

  reg_file reg_file_inst (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_wb      (wb),
    .i_raddr_a (raddr_a),
    .i_raddr_b (raddr_b),
    .o_rdata_a (rdata_a),
    .o_rdata_b (rdata_b)
  );

  decode_stage decode_stage_inst (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_instr_valid (i_instr_valid),
    .i_instr       (i_instr),
    .i_pc          (i_pc),
    .i_rdata_a     (rdata_a),
    .i_rdata_b     (rdata_b),
    .o_raddr_a     (raddr_a),
    .o_raddr_b     (raddr_b),
    .o_dec         (dec)
  );

  execute_stage #(
    .RESET_PC (RESET_PC)
  ) execute_stage_inst (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_dec          (dec),
    .i_wb           (wb),
    .o_exe          (exe),
    .o_branch_valid (o_branch_valid),
    .o_pcsrc        (o_pcsrc),
    .o_next_pc      (o_next_pc)
  );

  retire_stage retire_stage_inst (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_exe          (exe),
    .o_wb           (wb),
    .o_retire_valid (o_retire_valid),
    .o_retire_we    (o_retire_we),
    .o_retire_addr  (o_retire_addr),
    .o_retire_data  (o_retire_data)
  );

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  mips_pkg::dec_t    i_dec,
  input  mips_pkg::wb_t     i_wb,
  output mips_pkg::exe_t    o_exe,
  output logic              o_branch_valid,
  output logic              o_pcsrc,
  output logic [31:0]       o_next_pc
);

  mips_pkg::alu_op_e alu_ctrl;
  mips_pkg::exe_t    exe_d;
  logic              shamt_sel;    // shift amount as op1
  logic [4:0]        exe_waddr;
  logic              exe_fwd_ok;
  logic              wb_fwd_ok;
  logic [31:0]       rs_val;
  logic [31:0]       rt_val;
  logic [31:0]       ext_imm;
  logic [31:0]       alu_a;
  logic [31:0]       alu_b;
  logic [31:0]       alu_res;
  logic              zero;
  logic [31:0]       pc_plus4;
  logic [31:0]       br_target;
  logic [31:0]       jmp_target;
  logic              taken;

  // forwarding, newest first, never r0
  assign exe_waddr  = mips_pkg::exe_dest(o_exe);
  assign exe_fwd_ok = o_exe.valid & o_exe.ctrl.reg_write & (exe_waddr != 5'd0);
  assign wb_fwd_ok  = i_wb.valid & i_wb.we & (i_wb.waddr != 5'd0);

  always_comb begin
    if (exe_fwd_ok && exe_waddr == i_dec.rs) rs_val = mips_pkg::exe_wdata(o_exe);
    else if (wb_fwd_ok && i_wb.waddr == i_dec.rs) rs_val = i_wb.wdata;
    else rs_val = i_dec.op1;

    if (exe_fwd_ok && exe_waddr == i_dec.rt) rt_val = mips_pkg::exe_wdata(o_exe);
    else if (wb_fwd_ok && i_wb.waddr == i_dec.rt) rt_val = i_wb.wdata;
    else rt_val = i_dec.op2;
  end

  // ALU control from opcode and funct
  always_comb begin
    shamt_sel = 1'b0;
    alu_ctrl  = mips_pkg::ALU_ADD;
    case (i_dec.ctrl.op)
      mips_pkg::R_TYPE: begin
        case (mips_pkg::funct_e'(i_dec.imm[5:0]))
          mips_pkg::SUB: alu_ctrl = mips_pkg::ALU_SUB;
          mips_pkg::AND: alu_ctrl = mips_pkg::ALU_AND;
          mips_pkg::OR:  alu_ctrl = mips_pkg::ALU_OR;
          mips_pkg::XOR: alu_ctrl = mips_pkg::ALU_XOR;
          mips_pkg::NOR: alu_ctrl = mips_pkg::ALU_NOR;
          mips_pkg::SLT: alu_ctrl = mips_pkg::ALU_SLT;
          mips_pkg::SLL: begin
            alu_ctrl  = mips_pkg::ALU_SLL;
            shamt_sel = 1'b1;
          end
          mips_pkg::SRL: begin
            alu_ctrl  = mips_pkg::ALU_SRL;
            shamt_sel = 1'b1;
          end
          mips_pkg::SRA: begin
            alu_ctrl  = mips_pkg::ALU_SRA;
            shamt_sel = 1'b1;
          end
          default: alu_ctrl = mips_pkg::ALU_ADD;
        endcase
      end
      mips_pkg::SLTI: alu_ctrl = mips_pkg::ALU_SLT;
      mips_pkg::ANDI: alu_ctrl = mips_pkg::ALU_AND;
      mips_pkg::ORI:  alu_ctrl = mips_pkg::ALU_OR;
      mips_pkg::XORI: alu_ctrl = mips_pkg::ALU_XOR;
      mips_pkg::LUI:  alu_ctrl = mips_pkg::ALU_LUI;
      mips_pkg::BEQ, mips_pkg::BNE: alu_ctrl = mips_pkg::ALU_SUB;  // compare
      default: alu_ctrl = mips_pkg::ALU_ADD;
    endcase
  end

  assign ext_imm = i_dec.ctrl.ext_op ? {{16{i_dec.imm[15]}}, i_dec.imm[15:0]}
                                     : {16'b0, i_dec.imm[15:0]};
  assign alu_a   = shamt_sel ? {27'b0, i_dec.imm[10:6]} : rs_val;
  assign alu_b   = i_dec.ctrl.alu_src_op2 ? ext_imm : rt_val;

  alu alu_inst (
    .i_op1     (alu_a),
    .i_op2     (alu_b),
    .i_control (alu_ctrl),
    .o_result  (alu_res),
    .o_zero    (zero)
  );

  // next pc
  assign pc_plus4   = i_dec.pc + 32'd4;
  assign br_target  = pc_plus4 + {ext_imm[29:0], 2'b00};
  assign jmp_target = {pc_plus4[31:28], i_dec.imm, 2'b00};
  assign taken      = i_dec.ctrl.jump | (i_dec.ctrl.beq & zero) | (i_dec.ctrl.bne & ~zero);

  always_comb begin
    exe_d.valid    = i_dec.valid;
    exe_d.result   = alu_res;
    exe_d.rt       = i_dec.rt;
    exe_d.rd       = i_dec.rd;
    exe_d.ctrl     = i_dec.ctrl;
    exe_d.pc_plus4 = pc_plus4;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_exe.valid <= 1'b0;
      o_exe.ctrl  <= '0;
      o_pcsrc     <= 1'b0;
      o_next_pc   <= RESET_PC;
    end else begin
      o_exe   <= exe_d;
      o_pcsrc <= i_dec.valid & taken;
      if (i_dec.valid) begin
        o_next_pc <= taken ? (i_dec.ctrl.jump ? jmp_target : br_target) : pc_plus4;
      end
    end
  end

  assign o_branch_valid = o_exe.valid;

endmodule

// File: logic/mips_pkg.sv
package mips_pkg;

  typedef enum logic [5:0] {
    R_TYPE = 6'h00,
    J      = 6'h02,
    JAL    = 6'h03,
    BEQ    = 6'h04,
    BNE    = 6'h05,
    ADDI   = 6'h08,
    SLTI   = 6'h0a,
    ANDI   = 6'h0c,
    ORI    = 6'h0d,
    XORI   = 6'h0e,
    LUI    = 6'h0f
  } opcode_e;

  typedef enum logic [5:0] {
    SLL = 6'h00,
    SRL = 6'h02,
    SRA = 6'h03,
    ADD = 6'h20,
    SUB = 6'h22,
    AND = 6'h24,
    OR  = 6'h25,
    XOR = 6'h26,
    NOR = 6'h27,
    SLT = 6'h2a
  } funct_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_LUI
  } alu_op_e;

  typedef struct packed {
    logic    alu_src_op2; // extended immediate as op2
    logic    ext_op;      // 1 sign, 0 zero extend
    logic    reg_write;
    logic    reg_dst_rd;  // rd rather than rt
    logic    link;        // jal, pc+4 into r31
    logic    jump;
    logic    beq;
    logic    bne;
    opcode_e op;
  } ctrl_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [25:0] imm;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    ctrl_t       ctrl;
  } dec_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] result;
    logic [4:0]  rt;
    logic [4:0]  rd;
    ctrl_t       ctrl;
    logic [31:0] pc_plus4;
  } exe_t;

  typedef struct packed {
    logic        valid;
    logic        we;
    logic [4:0]  waddr;
    logic [31:0] wdata;
  } wb_t;

  // destination register of an executed instruction
  function automatic logic [4:0] exe_dest(input exe_t e);
    return e.ctrl.link ? 5'd31 : (e.ctrl.reg_dst_rd ? e.rd : e.rt);
  endfunction

  // value that instruction will write back
  function automatic logic [31:0] exe_wdata(input exe_t e);
    return e.ctrl.link ? e.pc_plus4 : e.result;
  endfunction

endpackage

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic             i_clk,
  input  logic             i_rst,
  input  mips_pkg::wb_t    i_wb,
  input  logic [4:0]       i_raddr_a,
  input  logic [4:0]       i_raddr_b,
  output logic [31:0]      o_rdata_a,
  output logic [31:0]      o_rdata_b
);

  logic [31:0] regs [32];
  logic        wr_en;

  assign wr_en = i_wb.valid & i_wb.we & (i_wb.waddr != 5'd0); // r0 stays zero

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[i_wb.waddr] <= i_wb.wdata;
    end
  end

  // write-first: same-cycle write is visible on the read port
  always_comb begin
    if (i_raddr_a == 5'd0) o_rdata_a = '0;
    else if (wr_en && i_wb.waddr == i_raddr_a) o_rdata_a = i_wb.wdata;
    else o_rdata_a = regs[i_raddr_a];

    if (i_raddr_b == 5'd0) o_rdata_b = '0;
    else if (wr_en && i_wb.waddr == i_raddr_b) o_rdata_b = i_wb.wdata;
    else o_rdata_b = regs[i_raddr_b];
  end

endmodule

// File: logic/retire_stage.sv
`timescale 1ns/1ps

module retire_stage (
  input  logic              i_clk,
  input  logic              i_rst,
  input  mips_pkg::exe_t    i_exe,
  output mips_pkg::wb_t     o_wb,
  output logic              o_retire_valid,
  output logic              o_retire_we,
  output logic [4:0]        o_retire_addr,
  output logic [31:0]       o_retire_data
);

  mips_pkg::wb_t wb_d;
  logic [4:0]    dest;

  assign dest = mips_pkg::exe_dest(i_exe);  // r31 for jal

  always_comb begin
    wb_d.valid = i_exe.valid;
    wb_d.we    = i_exe.valid & i_exe.ctrl.reg_write & (dest != 5'd0);  // r0 write dropped
    wb_d.waddr = dest;
    wb_d.wdata = mips_pkg::exe_wdata(i_exe);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_wb.valid <= 1'b0;
      o_wb.we    <= 1'b0;
    end else begin
      o_wb <= wb_d;
    end
  end

  assign o_retire_valid = o_wb.valid;
  assign o_retire_we    = o_wb.we;
  assign o_retire_addr  = o_wb.waddr;
  assign o_retire_data  = o_wb.wdata;

endmodule

// File: tb.f
logic/mips_pkg.sv
logic/reg_file.sv
logic/alu.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/retire_stage.sv
logic/exec_core_top.sv
verification/tb_clk_gen.sv
verification/exec_core_chk.sv
verification/exec_core_monitor.sv
verification/exec_core_tb.sv

// File: verification/exec_core_chk.sv
`timescale 1ns/1ps

module exec_core_chk (
  input logic       i_clk,
  input logic       i_rst,
  input logic       i_branch_valid,
  input logic       i_pcsrc,
  input logic       i_retire_valid,
  input logic       i_retire_we,
  input logic [4:0] i_retire_addr
);

  // retire is one register after the branch decision
  retire_follows_branch: assert property (@(posedge i_clk) disable iff (i_rst)
    i_retire_valid == $past(i_branch_valid))
    else $error("retire valid is not branch valid delayed by one cycle");

  no_write_to_r0: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_retire_we && i_retire_addr == 5'd0))
    else $error("write enable raised for register 0");

  pcsrc_only_when_valid: assert property (@(posedge i_clk) disable iff (i_rst)
    !i_branch_valid |-> !i_pcsrc)
    else $error("pc select raised without a valid branch decision");

endmodule

bind exec_core_top exec_core_chk exec_core_chk_inst (
  .i_clk          (i_clk),
  .i_rst          (i_rst),
  .i_branch_valid (o_branch_valid),
  .i_pcsrc        (o_pcsrc),
  .i_retire_valid (o_retire_valid),
  .i_retire_we    (o_retire_we),
  .i_retire_addr  (o_retire_addr)
);

// File: verification/exec_core_monitor.sv
`timescale 1ns/1ps

module exec_core_monitor #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_instr_valid,
  input  logic [31:0] i_instr,
  input  logic [31:0] i_pc,
  input  logic        i_branch_valid,
  input  logic        i_pcsrc,
  input  logic [31:0] i_next_pc,
  input  logic        i_retire_valid,
  input  logic        i_retire_we,
  input  logic [4:0]  i_retire_addr,
  input  logic [31:0] i_retire_data,
  output int          o_checks,
  output int          o_errors,
  output int          o_pending
);

  localparam int BRANCH_LATENCY = 2;  // cycles from issue to pc decision

  typedef struct packed {
    logic        we;
    logic [4:0]  addr;
    logic [31:0] data;
    logic [31:0] pc;
  } retire_t;

  logic [31:0] model [32];   // sequential register state
  logic [95:0] issue_q [$];  // {cycle, pc, instr}
  retire_t     retire_q [$];
  int          checks = 0;
  int          errors = 0;
  int          pending = 0;
  int          cycle = 0;

  assign o_checks  = checks;
  assign o_errors  = errors;
  assign o_pending = pending;

  task automatic compare(input string what, input logic [31:0] pc,
                         input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s for pc %h, got %h, expected %h", $time, what, pc, got, exp);
    end
  endtask

  // architectural result of one instruction, applied to the model in order
  task automatic predict(input logic [31:0] pc, input logic [31:0] word,
                         output logic pcsrc, output logic [31:0] next_pc,
                         output retire_t exp);
    logic [4:0]  dst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_s;
    logic [31:0] imm_z;
    logic [31:0] pc4;
    logic [31:0] res;
    logic        wr;
    a       = model[word[25:21]];
    b       = model[word[20:16]];
    imm_s   = {{16{word[15]}}, word[15:0]};
    imm_z   = {16'b0, word[15:0]};
    pc4     = pc + 32'd4;
    pcsrc   = 1'b0;
    next_pc = pc4;
    dst     = word[20:16];
    wr      = 1'b1;
    res     = 32'd0;
    case (word[31:26])
      6'h00: begin  // R-type by funct
        dst = word[15:11];
        case (word[5:0])
          6'h00: res = b << word[10:6];
          6'h02: res = b >> word[10:6];
          6'h03: res = $unsigned($signed(b) >>> word[10:6]);
          6'h22: res = a - b;
          6'h24: res = a & b;
          6'h25: res = a | b;
          6'h26: res = a ^ b;
          6'h27: res = ~(a | b);
          6'h2a: res = {31'b0, $signed(a) < $signed(b)};
          default: res = a + b;  // add
        endcase
      end
      6'h08: res = a + imm_s;  // addi
      6'h0a: res = {31'b0, $signed(a) < $signed(imm_s)};  // slti
      6'h0c: res = a & imm_z;
      6'h0d: res = a | imm_z;
      6'h0e: res = a ^ imm_z;
      6'h0f: res = {word[15:0], 16'b0};  // lui
      6'h04, 6'h05: begin  // beq 04, bne 05
        wr = 1'b0;
        if ((a == b) == (word[31:26] == 6'h04)) begin
          pcsrc   = 1'b1;
          next_pc = pc4 + (imm_s << 2);
        end
      end
      6'h02, 6'h03: begin  // j 02, jal 03
        pcsrc   = 1'b1;
        next_pc = {pc4[31:28], word[25:0], 2'b00};
        wr      = word[26];  // only jal links
        dst     = 5'd31;
        res     = pc4;
      end
      default: wr = 1'b0;
    endcase
    exp.we   = wr && (dst != 5'd0);
    exp.addr = dst;
    exp.data = res;
    exp.pc   = pc;
    if (exp.we) model[dst] = res;
  endtask

  always @(posedge i_clk) begin
    if (i_rst) begin
      issue_q.delete();
      retire_q.delete();
      for (int i = 0; i < 32; i++) model[i] = 32'd0;
    end else if (i_instr_valid) begin
      issue_q.push_back({cycle, i_pc, i_instr});
    end
    cycle++;
  end

  // outputs are compared half a cycle after they change
  always @(negedge i_clk) begin
    logic [95:0] ent;
    logic        exp_pcsrc;
    logic [31:0] exp_next;
    retire_t     exp;
    if (i_rst) begin
      compare("reset next pc", RESET_PC, i_next_pc, RESET_PC);
      compare("reset flags", RESET_PC,
              {28'b0, i_branch_valid, i_pcsrc, i_retire_valid, i_retire_we}, 32'd0);
    end
    if (!i_rst && i_retire_valid) begin
      if (retire_q.size() == 0) begin
        errors++;
        $display("Error at %0t: a retire came out with no instruction in flight", $time);
      end else begin
        exp = retire_q.pop_front();
        compare("write enable", exp.pc, {31'b0, i_retire_we}, {31'b0, exp.we});
        if (exp.we && i_retire_we) begin
          compare("write address", exp.pc, {27'b0, i_retire_addr}, {27'b0, exp.addr});
          compare("write data", exp.pc, i_retire_data, exp.data);
        end
      end
    end
    if (!i_rst && i_branch_valid) begin
      if (issue_q.size() == 0) begin
        errors++;
        $display("Error at %0t: a branch decision came out with nothing issued", $time);
      end else begin
        ent = issue_q.pop_front();
        predict(ent[63:32], ent[31:0], exp_pcsrc, exp_next, exp);
        compare("decision latency", ent[63:32], cycle - ent[95:64], BRANCH_LATENCY);
        compare("pc select", ent[63:32], {31'b0, i_pcsrc}, {31'b0, exp_pcsrc});
        compare("next pc", ent[63:32], i_next_pc, exp_next);
        retire_q.push_back(exp);
      end
    end
    pending = issue_q.size() + retire_q.size();
  end

endmodule

// File: verification/exec_core_tb.sv
`timescale 1ns/1ps

module exec_core_tb;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
  } stim_t;

  localparam logic [31:0] RESET_PC     = 32'h0000_0100;
  localparam int          RANDOM_COUNT = 40;
  localparam int          RESET_LIMIT  = 20;
  localparam int          DRAIN_LIMIT  = 50;

  logic        clk;
  logic        rst;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        branch_valid;
  logic        pcsrc;
  logic [31:0] next_pc;
  logic        retire_valid;
  logic        retire_we;
  logic [4:0]  retire_addr;
  logic [31:0] retire_data;
  int          checks;
  int          check_errors;
  int          pending;
  int          timeouts = 0;
  integer      seed = 32'h6443_40bc;
  stim_t       table_q [$];

  tb_clk_gen #(.HALF_PERIOD(5), .RST_CYCLES(4)) tb_clk_gen_inst (
    .o_clk (clk),
    .o_rst (rst)
  );

  exec_core_top #(.RESET_PC(RESET_PC)) exec_core_top_inst (
    .i_clk          (clk),
    .i_rst          (rst),
    .i_instr_valid  (instr_valid),
    .i_instr        (instr),
    .i_pc           (pc),
    .o_branch_valid (branch_valid),
    .o_pcsrc        (pcsrc),
    .o_next_pc      (next_pc),
    .o_retire_valid (retire_valid),
    .o_retire_we    (retire_we),
    .o_retire_addr  (retire_addr),
    .o_retire_data  (retire_data)
  );

  exec_core_monitor #(.RESET_PC(RESET_PC)) exec_core_monitor_inst (
    .i_clk          (clk),
    .i_rst          (rst),
    .i_instr_valid  (instr_valid),
    .i_instr        (instr),
    .i_pc           (pc),
    .i_branch_valid (branch_valid),
    .i_pcsrc        (pcsrc),
    .i_next_pc      (next_pc),
    .i_retire_valid (retire_valid),
    .i_retire_we    (retire_we),
    .i_retire_addr  (retire_addr),
    .i_retire_data  (retire_data),
    .o_checks       (checks),
    .o_errors       (check_errors),
    .o_pending      (pending)
  );

  function automatic logic [31:0] encode_r(input mips_pkg::funct_e fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] sh);
    return {mips_pkg::R_TYPE, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] encode_i(input mips_pkg::opcode_e op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encode_j(input mips_pkg::opcode_e op,
                                           input logic [25:0] target);
    return {op, target};
  endfunction

  // pcs run on sequentially, the caller never redirects
  task automatic add_row(input logic [31:0] word);
    table_q.push_back({RESET_PC + (32'(table_q.size()) << 2), word});
  endtask

  task automatic make_random_word(output logic [31:0] word);
    logic [31:0] r;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    r  = $random(seed);
    rs = {2'b0, r[2:0]};  // r0..r7 keeps dependencies dense
    rt = {2'b0, r[5:3]};
    rd = {2'b0, r[8:6]};
    case (r[12:9])
      4'd0: word = encode_r(mips_pkg::ADD, rs, rt, rd, 5'd0);
      4'd1: word = encode_r(mips_pkg::SUB, rs, rt, rd, 5'd0);
      4'd2: word = encode_r(mips_pkg::AND, rs, rt, rd, 5'd0);
      4'd3: word = encode_r(mips_pkg::OR, rs, rt, rd, 5'd0);
      4'd4: word = encode_r(mips_pkg::XOR, rs, rt, rd, 5'd0);
      4'd5: word = encode_r(mips_pkg::NOR, rs, rt, rd, 5'd0);
      4'd6: word = encode_r(mips_pkg::SLT, rs, rt, rd, 5'd0);
      4'd7: word = encode_r(mips_pkg::SLL, 5'd0, rt, rd, r[17:13]);
      4'd8: word = encode_r(mips_pkg::SRL, 5'd0, rt, rd, r[17:13]);
      4'd9: word = encode_r(mips_pkg::SRA, 5'd0, rt, rd, r[17:13]);
      4'd10: word = encode_i(mips_pkg::ADDI, rs, rt, r[31:16]);
      4'd11: word = encode_i(mips_pkg::SLTI, rs, rt, r[31:16]);
      4'd12: word = encode_i(mips_pkg::ANDI, rs, rt, r[31:16]);
      4'd13: word = encode_i(mips_pkg::ORI, rs, rt, r[31:16]);
      4'd14: word = encode_i(mips_pkg::XORI, rs, rt, r[31:16]);
      4'd15: word = encode_i(mips_pkg::LUI, 5'd0, rt, r[31:16]);
    endcase
  endtask

  task automatic build_table();
    logic [31:0] word;
    add_row(encode_i(mips_pkg::ADDI, 5'd0, 5'd1, 16'hfffb));   // r1 = -5
    add_row(encode_i(mips_pkg::ADDI, 5'd0, 5'd2, 16'h1234));
    add_row(encode_i(mips_pkg::ANDI, 5'd1, 5'd3, 16'hf0f0));   // zero extended
    add_row(encode_i(mips_pkg::ORI, 5'd1, 5'd4, 16'h8000));
    add_row(encode_i(mips_pkg::XORI, 5'd2, 5'd5, 16'hffff));
    add_row(encode_i(mips_pkg::SLTI, 5'd1, 5'd6, 16'hffff));   // -5 < -1
    add_row(encode_i(mips_pkg::SLTI, 5'd2, 5'd7, 16'h0005));
    add_row(encode_i(mips_pkg::LUI, 5'd0, 5'd8, 16'h8765));
    add_row(encode_r(mips_pkg::ADD, 5'd1, 5'd2, 5'd9, 5'd0));
    add_row(encode_r(mips_pkg::SUB, 5'd9, 5'd2, 5'd10, 5'd0));  // distance 1
    add_row(encode_r(mips_pkg::AND, 5'd10, 5'd8, 5'd11, 5'd0)); // r8 at distance 3
    add_row(encode_r(mips_pkg::OR, 5'd11, 5'd5, 5'd12, 5'd0));
    add_row(encode_r(mips_pkg::XOR, 5'd12, 5'd11, 5'd13, 5'd0)); // distances 1 and 2
    add_row(encode_r(mips_pkg::NOR, 5'd13, 5'd0, 5'd14, 5'd0));
    add_row(encode_r(mips_pkg::SLT, 5'd1, 5'd2, 5'd15, 5'd0));
    add_row(encode_r(mips_pkg::SLL, 5'd0, 5'd8, 5'd16, 5'd4));
    add_row(encode_r(mips_pkg::SRL, 5'd0, 5'd8, 5'd17, 5'd4));
    add_row(encode_r(mips_pkg::SRA, 5'd0, 5'd8, 5'd18, 5'd4));  // r8 is negative
    add_row(encode_i(mips_pkg::ADDI, 5'd1, 5'd0, 16'h0007));   // dropped r0 write
    add_row(encode_r(mips_pkg::ADD, 5'd0, 5'd1, 5'd19, 5'd0));
    add_row(encode_i(mips_pkg::BEQ, 5'd1, 5'd1, 16'h0003));    // taken
    add_row(encode_i(mips_pkg::BEQ, 5'd1, 5'd2, 16'hfffe));
    add_row(encode_i(mips_pkg::BNE, 5'd1, 5'd2, 16'hfffc));    // taken backward
    add_row(encode_i(mips_pkg::BNE, 5'd2, 5'd2, 16'h0008));
    add_row(encode_j(mips_pkg::J, 26'h000_0040));
    add_row(encode_j(mips_pkg::JAL, 26'h000_0080));
    add_row(encode_r(mips_pkg::ADD, 5'd31, 5'd0, 5'd20, 5'd0)); // link value forwarded
    add_row(encode_r(mips_pkg::SUB, 5'd31, 5'd20, 5'd21, 5'd0));
    add_row(encode_r(mips_pkg::ADD, 5'd0, 5'd0, 5'd22, 5'd0));
    for (int i = 0; i < RANDOM_COUNT; i++) begin
      make_random_word(word);
      add_row(word);
    end
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst && cycles < RESET_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (rst) begin
      timeouts++;
      $display("Timeout: reset was still high after %0d cycles", RESET_LIMIT);
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    repeat (2) @(posedge clk);
    while (pending != 0 && cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (pending != 0) begin
      timeouts++;
      $display("Timeout: %0d instructions were still in the pipeline", pending);
    end
  endtask

  initial begin
    instr_valid = 1'b0;
    instr       = 32'd0;
    pc          = 32'd0;
    build_table();
    wait_reset_release();
    foreach (table_q[i]) begin
      @(negedge clk);
      instr_valid = 1'b1;
      pc          = table_q[i].pc;
      instr       = table_q[i].instr;
    end
    @(negedge clk);
    instr_valid = 1'b0;
    wait_drain();
    $display("checks %0d, check errors %0d, timeouts %0d", checks, check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0 && checks > 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_PERIOD = 5,
  parameter int RST_CYCLES  = 4
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst = 1'b0;  // released on a falling edge like every DUT input
  end

endmodule
